/* mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// TLB size in entries, power of two
`define MMU_TLB_ENTRIES 8

// Matching queue depth
// Bounds the reads in flight on the memory port
`define MMU_TAGQ_DEPTH 8

// Flags queue depth
// One slot per core read in flight
`define MMU_FLAGQ_DEPTH 8

// Page offset width
// 4 KiB pages
`define MMU_PAGE_BITS 12

`endif

/* mmu_pkg.sv */
`include "mmu_macros.svh"

package mmu_pkg;

	// Translation mode from the core
	typedef enum logic {
		BYPASS    = 1'b0,
		ONE_LEVEL = 1'b1
	} mode_e;

	// Owner of an outstanding memory read
	typedef enum logic {
		TAG_CORE = 1'b0,
		TAG_WALK = 1'b1
	} req_tag_e;

	// Page-table entry flags
	// Entry bits 11 to 1
	typedef logic [`MMU_PAGE_BITS-2:0] pte_flags_t;

	// Virtual page number
	typedef logic [31-`MMU_PAGE_BITS:0] vpn_t;

	// Physical frame number
	typedef logic [31-`MMU_PAGE_BITS:0] pfn_t;

	// One-level page-table entry layout
	// Frame on top, valid in bit 0
	typedef struct packed {
		pfn_t       frame;
		pte_flags_t flags;
		logic       valid;
	} pte_t;

endpackage

/* mem_req_if.sv */
// Memory request channel from the translator to the port control
// Fields hold steady while valid is high and ready is low
interface mem_req_if;

	logic               valid;
	logic               ready;
	// 1 for a store
	logic               rw;
	logic [31:0]        addr;
	logic [31:0]        wdata;
	logic [3:0]         mask;
	// Who gets the read data back
	mmu_pkg::req_tag_e  tag;

	// Translator side
	modport src (
		output valid, rw, addr, wdata, mask, tag,
		input  ready
	);

	// Port control side
	modport dst (
		input  valid, rw, addr, wdata, mask, tag,
		output ready
	);

endinterface

/* resp_fifo.sv */
module resp_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 8
) (
	input  logic     iCLOCK,
	input  logic     inRESET,
	input  logic     flush,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t       buf_mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	// One extra bit so a full buffer is countable
	logic [AW:0]    count;
	logic           push_ok;
	logic           pop_ok;

	assign full     = (count == (AW+1)'(DEPTH));
	assign empty    = (count == '0);
	assign push_ok  = push && !full;
	assign pop_ok   = pop && !empty;
	// Show-ahead, head is always visible
	assign pop_data = buf_mem[rd_ptr];

	// Pointers and fill level
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// Drop everything in one cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge iCLOCK) begin
		if (push_ok)
			buf_mem[wr_ptr] <= push_data;
	end

	// Caller must respect the flags
	a_no_overflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		push && !flush |-> !full);
	a_no_underflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		pop && !flush |-> !empty);

endmodule

/* mmu_tlb.sv */
`include "mmu_macros.svh"

module mmu_tlb (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                flush,
	input  mmu_pkg::vpn_t       lookup_vpn,
	output logic                hit,
	output mmu_pkg::pfn_t       hit_pfn,
	output mmu_pkg::pte_flags_t hit_flags,
	input  logic                fill,
	input  mmu_pkg::vpn_t       fill_vpn,
	input  mmu_pkg::pfn_t       fill_pfn,
	input  mmu_pkg::pte_flags_t fill_flags
);

	localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);
	localparam int VPN_W = $bits(mmu_pkg::vpn_t);

	// Tag is the page number above the index bits
	logic [VPN_W-1:IDX_W]           tag_mem   [`MMU_TLB_ENTRIES];
	mmu_pkg::pfn_t                  pfn_mem   [`MMU_TLB_ENTRIES];
	mmu_pkg::pte_flags_t            flags_mem [`MMU_TLB_ENTRIES];
	logic [`MMU_TLB_ENTRIES-1:0]    entry_valid;
	logic [IDX_W-1:0]               lookup_idx;
	logic [IDX_W-1:0]               fill_idx;

	// Direct mapped on the low page-number bits
	assign lookup_idx = lookup_vpn[IDX_W-1:0];
	assign fill_idx   = fill_vpn[IDX_W-1:0];

	// Combinational lookup
	assign hit       = entry_valid[lookup_idx]
	                   && (tag_mem[lookup_idx] == lookup_vpn[VPN_W-1:IDX_W]);
	assign hit_pfn   = pfn_mem[lookup_idx];
	assign hit_flags = flags_mem[lookup_idx];

	// Valid bits
	// flush beats a fill in the same cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			entry_valid <= '0;
		else if (flush)
			entry_valid <= '0;
		else if (fill)
			entry_valid[fill_idx] <= 1'b1;
	end

	// Entry contents, overwrite on fill
	always_ff @(posedge iCLOCK) begin
		if (fill) begin
			tag_mem[fill_idx]   <= fill_vpn[VPN_W-1:IDX_W];
			pfn_mem[fill_idx]   <= fill_pfn;
			flags_mem[fill_idx] <= fill_flags;
		end
	end

endmodule

/* mmu_translate.sv */
`include "mmu_macros.svh"

module mmu_translate (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                tlb_flush,
	input  mmu_pkg::mode_e      mode,
	input  logic [31:0]         pdt,
	input  logic                req_valid,
	output logic                req_ready,
	input  logic                req_rw,
	input  logic [31:0]         req_addr,
	input  logic [31:0]         req_wdata,
	input  logic [3:0]          req_mask,
	mem_req_if.src              mem,
	input  logic                pte_valid,
	input  logic [31:0]         pte_data,
	input  logic                fault_clear,
	output logic                fault,
	output mmu_pkg::pte_flags_t req_flags
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WALK_ISSUE,
		ST_WALK_WAIT,
		ST_ISSUE,
		ST_FAULT
	} state_t;

	state_t                     state;
	// Low during reset and the first cycle after it
	logic                       run;
	logic                       accept;
	// Registered core access
	logic                       b_rw;
	logic [31:0]                b_addr;
	logic [31:0]                b_wdata;
	logic [3:0]                 b_mask;
	// Address and flags of the request being issued
	logic [31:0]                b_paddr;
	mmu_pkg::pte_flags_t        b_flags;
	mmu_pkg::vpn_t              vpn;
	logic [`MMU_PAGE_BITS-1:0]  offset;
	mmu_pkg::pte_t              pte;
	logic                       tlb_hit;
	mmu_pkg::pfn_t              tlb_pfn;
	mmu_pkg::pte_flags_t        tlb_flags;
	logic                       tlb_fill;

	assign vpn      = b_addr[31:`MMU_PAGE_BITS];
	assign offset   = b_addr[`MMU_PAGE_BITS-1:0];
	assign pte      = mmu_pkg::pte_t'(pte_data);
	// Good entry back from the walk
	assign tlb_fill = (state == ST_WALK_WAIT) && pte_valid && pte.valid;

	// Take a new access when idle, or right behind an issue that goes out
	assign req_ready = run && ((state == ST_IDLE) || ((state == ST_ISSUE) && mem.ready));
	assign accept    = req_valid && req_ready;

	mmu_tlb i_tlb (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.flush      (tlb_flush),
		.lookup_vpn (vpn),
		.hit        (tlb_hit),
		.hit_pfn    (tlb_pfn),
		.hit_flags  (tlb_flags),
		.fill       (tlb_fill),
		.fill_vpn   (vpn),
		.fill_pfn   (pte.frame),
		.fill_flags (pte.flags)
	);

	// Control FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
			run   <= 1'b0;
		end else begin
			run <= 1'b1;
			case (state)
				ST_IDLE:
					if (accept)
						state <= ST_LOOKUP;
				ST_LOOKUP:
					if ((mode == mmu_pkg::BYPASS) || tlb_hit)
						state <= ST_ISSUE;
					else
						state <= ST_WALK_ISSUE;
				ST_WALK_ISSUE:
					if (mem.ready)
						state <= ST_WALK_WAIT;
				ST_WALK_WAIT:
					if (pte_valid)
						state <= pte.valid ? ST_ISSUE : ST_FAULT;
				ST_ISSUE:
					if (mem.ready)
						state <= accept ? ST_LOOKUP : ST_IDLE;
				// Parked until the control has drained and flushed
				ST_FAULT:
					if (fault_clear)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Access and translation registers
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			b_rw    <= req_rw;
			b_addr  <= req_addr;
			b_wdata <= req_wdata;
			b_mask  <= req_mask;
		end
		if (state == ST_LOOKUP) begin
			if (mode == mmu_pkg::BYPASS) begin
				b_paddr <= b_addr;
				b_flags <= '0;
			end else if (tlb_hit) begin
				b_paddr <= {tlb_pfn, offset};
				b_flags <= tlb_flags;
			end else begin
				// Entry address, four bytes per page
				b_paddr <= pdt + 32'({vpn, 2'b00});
			end
		end
		if (tlb_fill) begin
			b_paddr <= {pte.frame, offset};
			b_flags <= pte.flags;
		end
	end

	// Walk reads are always full-word loads
	assign mem.valid = (state == ST_WALK_ISSUE) || (state == ST_ISSUE);
	assign mem.rw    = (state == ST_ISSUE) ? b_rw : 1'b0;
	assign mem.addr  = b_paddr;
	assign mem.wdata = b_wdata;
	assign mem.mask  = (state == ST_ISSUE) ? b_mask : 4'hf;
	assign mem.tag   = (state == ST_ISSUE) ? mmu_pkg::TAG_CORE : mmu_pkg::TAG_WALK;

	assign fault     = (state == ST_FAULT);
	assign req_flags = b_flags;

	// A stalled request stays put until the control takes it
	a_req_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr) && $stable(mem.tag));

endmodule

/* mmu_ctrl.sv */
module mmu_ctrl (
	input  logic                iCLOCK,
	input  logic                inRESET,
	mem_req_if.dst              xl,
	input  logic                fault,
	output logic                fault_clear,
	output logic                pte_valid,
	output logic [31:0]         pte_data,
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output logic                mem_req_rw,
	output logic [31:0]         mem_req_addr,
	output logic [31:0]         mem_req_wdata,
	output logic [3:0]          mem_req_mask,
	input  logic                mem_resp_valid,
	output logic                mem_resp_ready,
	input  logic [31:0]         mem_resp_data,
	output logic                resp_valid,
	input  logic                resp_ready,
	output logic [31:0]         resp_data,
	output mmu_pkg::pte_flags_t resp_flags,
	output logic                store_ack,
	output logic                page_fault,
	output logic                tagq_push,
	output mmu_pkg::req_tag_e   tagq_tag,
	input  logic                tagq_full,
	output logic                tagq_pop,
	input  mmu_pkg::req_tag_e   tagq_head,
	input  logic                tagq_empty,
	output logic                flagq_push,
	input  logic                flagq_full,
	output logic                flagq_pop,
	input  mmu_pkg::pte_flags_t flagq_head,
	output logic                queue_flush
);

	typedef enum logic [1:0] {
		PF_IDLE,
		PF_DRAIN,
		PF_SIGNAL
	} pf_state_t;

	pf_state_t  pf_state;
	logic       gate;
	logic       req_accept;
	logic       resp_accept;
	logic       pf_pulse;

	// Memory request gating
	assign gate          = !tagq_full && !flagq_full && !fault && (pf_state == PF_IDLE);
	assign mem_req_valid = xl.valid && gate;
	assign xl.ready      = mem_req_ready && gate;
	assign mem_req_rw    = xl.rw;
	assign mem_req_addr  = xl.addr;
	assign mem_req_wdata = xl.wdata;
	assign mem_req_mask  = xl.mask;
	assign req_accept    = mem_req_valid && mem_req_ready;

	// Only reads come back, so only reads get a tag
	assign tagq_push  = req_accept && !xl.rw;
	assign tagq_tag   = xl.tag;
	assign flagq_push = tagq_push && (xl.tag == mmu_pkg::TAG_CORE);

	// Nothing to take with no read outstanding or a core response still held
	assign mem_resp_ready = !tagq_empty && !resp_valid;
	assign resp_accept    = mem_resp_valid && mem_resp_ready;

	// Route by the head tag
	assign tagq_pop  = resp_accept;
	assign pte_valid = resp_accept && (tagq_head == mmu_pkg::TAG_WALK);
	assign pte_data  = mem_resp_data;
	assign flagq_pop = resp_accept && (tagq_head == mmu_pkg::TAG_CORE);

	// Fault sequence
	// Drain also waits on the output latch so no earlier read is lost
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pf_state <= PF_IDLE;
		end else begin
			case (pf_state)
				PF_IDLE:
					if (fault)
						pf_state <= PF_DRAIN;
				PF_DRAIN:
					if (tagq_empty && !resp_valid)
						pf_state <= PF_SIGNAL;
				default:
					pf_state <= PF_IDLE;
			endcase
		end
	end

	assign pf_pulse    = (pf_state == PF_SIGNAL);
	assign page_fault  = pf_pulse;
	assign queue_flush = pf_pulse;
	assign fault_clear = pf_pulse;

	// Store ack one cycle after memory takes the store
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			store_ack <= 1'b0;
		else
			store_ack <= req_accept && xl.rw;
	end

	// Output latch valid
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			resp_valid <= 1'b0;
		else if (pf_pulse)
			resp_valid <= 1'b0;
		else if (flagq_pop)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	// Output latch payload
	always_ff @(posedge iCLOCK) begin
		if (flagq_pop) begin
			resp_data  <= mem_resp_data;
			resp_flags <= flagq_head;
		end
	end

	// Memory must not answer a read that was never issued
	a_resp_has_tag: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_resp_valid |-> !tagq_empty);

endmodule

/* mmu_if.sv */
`include "mmu_macros.svh"

module mmu_if (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                tlb_flush,
	input  mmu_pkg::mode_e      mode,
	input  logic [31:0]         pdt,
	// Core requests
	input  logic                req_valid,
	output logic                req_ready,
	input  logic                req_rw,
	input  logic [31:0]         req_addr,
	input  logic [31:0]         req_wdata,
	input  logic [3:0]          req_mask,
	// Core responses and pulses
	output logic                resp_valid,
	input  logic                resp_ready,
	output logic [31:0]         resp_data,
	output mmu_pkg::pte_flags_t resp_flags,
	output logic                store_ack,
	output logic                page_fault,
	// Memory requests
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	output logic                mem_req_rw,
	output logic [31:0]         mem_req_addr,
	output logic [31:0]         mem_req_wdata,
	output logic [3:0]          mem_req_mask,
	// Memory responses, in order
	input  logic                mem_resp_valid,
	output logic                mem_resp_ready,
	input  logic [31:0]         mem_resp_data
);

	mem_req_if              xl_req ();

	logic                   fault;
	logic                   fault_clear;
	logic                   pte_valid;
	logic [31:0]            pte_data;
	mmu_pkg::pte_flags_t    req_flags;
	logic                   queue_flush;
	// Matching queue
	logic                   tagq_push;
	mmu_pkg::req_tag_e      tagq_tag;
	logic                   tagq_full;
	logic                   tagq_pop;
	mmu_pkg::req_tag_e      tagq_head;
	logic                   tagq_empty;
	// Flags queue
	logic                   flagq_push;
	logic                   flagq_full;
	logic                   flagq_pop;
	mmu_pkg::pte_flags_t    flagq_head;

	mmu_translate i_translate (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.tlb_flush   (tlb_flush),
		.mode        (mode),
		.pdt         (pdt),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_rw      (req_rw),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.req_mask    (req_mask),
		.mem         (xl_req.src),
		.pte_valid   (pte_valid),
		.pte_data    (pte_data),
		.fault_clear (fault_clear),
		.fault       (fault),
		.req_flags   (req_flags)
	);

	mmu_ctrl i_ctrl (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.xl             (xl_req.dst),
		.fault          (fault),
		.fault_clear    (fault_clear),
		.pte_valid      (pte_valid),
		.pte_data       (pte_data),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_rw     (mem_req_rw),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_req_mask   (mem_req_mask),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_ready (mem_resp_ready),
		.mem_resp_data  (mem_resp_data),
		.resp_valid     (resp_valid),
		.resp_ready     (resp_ready),
		.resp_data      (resp_data),
		.resp_flags     (resp_flags),
		.store_ack      (store_ack),
		.page_fault     (page_fault),
		.tagq_push      (tagq_push),
		.tagq_tag       (tagq_tag),
		.tagq_full      (tagq_full),
		.tagq_pop       (tagq_pop),
		.tagq_head      (tagq_head),
		.tagq_empty     (tagq_empty),
		.flagq_push     (flagq_push),
		.flagq_full     (flagq_full),
		.flagq_pop      (flagq_pop),
		.flagq_head     (flagq_head),
		.queue_flush    (queue_flush)
	);

	// One tag per outstanding read
	resp_fifo #(
		.payload_t (mmu_pkg::req_tag_e),
		.DEPTH     (`MMU_TAGQ_DEPTH)
	) i_tagq (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (queue_flush),
		.push      (tagq_push),
		.push_data (tagq_tag),
		.full      (tagq_full),
		.pop       (tagq_pop),
		.pop_data  (tagq_head),
		.empty     (tagq_empty)
	);

	// Flags ride along with core reads only
	// Translator flags feed it straight
	resp_fifo #(
		.payload_t (mmu_pkg::pte_flags_t),
		.DEPTH     (`MMU_FLAGQ_DEPTH)
	) i_flagq (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (queue_flush),
		.push      (flagq_push),
		.push_data (req_flags),
		.full      (flagq_full),
		.pop       (flagq_pop),
		.pop_data  (flagq_head),
		.empty     ()
	);

endmodule

/* tb_mem_model.sv */
// Behavioral memory behind the MMU
// 4096 words, random request ready, random in-order read latency
module tb_mem_model (
	input  logic        iCLOCK,
	input  logic        inRESET,
	// Start of the page-table page, for counting walk reads
	input  logic [31:0] pt_base,
	input  logic        mem_req_valid,
	output logic        mem_req_ready,
	input  logic        mem_req_rw,
	input  logic [31:0] mem_req_addr,
	input  logic [31:0] mem_req_wdata,
	input  logic [3:0]  mem_req_mask,
	output logic        mem_resp_valid,
	input  logic        mem_resp_ready,
	output logic [31:0] mem_resp_data,
	output int          pt_reads
);
	timeunit 1ns;
	timeprecision 1ps;

	// Loaded by the testbench top
	logic [31:0] mem [4096];
	// Read data captured at accept, oldest first
	logic [31:0] rd_q [$];
	logic [11:0] idx;
	logic        resp_taken;
	int          lane;
	int          seed = 32'h357e;

	initial begin
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data  = '0;
		pt_reads       = 0;
		resp_taken     = 1'b0;
	end

	// Sample both channels on the rising edge
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			if (mem_req_valid && mem_req_ready) begin
				idx = mem_req_addr[13:2];
				if (mem_req_rw) begin
					for (lane = 0; lane < 4; lane++)
						if (mem_req_mask[lane])
							mem[idx][8*lane +: 8] = mem_req_wdata[8*lane +: 8];
				end else begin
					rd_q.push_back(mem[idx]);
					// Walk reads land in the page-table page
					if ((mem_req_addr - pt_base) < 32'h1000)
						pt_reads++;
				end
			end
			if (mem_resp_valid && mem_resp_ready) begin
				void'(rd_q.pop_front());
				resp_taken = 1'b1;
			end
		end
	end

	// New outputs on the falling edge
	always @(negedge iCLOCK) begin
		if (!inRESET) begin
			mem_req_ready  = 1'b0;
			mem_resp_valid = 1'b0;
		end else begin
			// Ready about three cycles in four
			mem_req_ready = (($random(seed) & 3) != 0);
			if (resp_taken) begin
				mem_resp_valid = 1'b0;
				resp_taken     = 1'b0;
			end
			// Valid holds until taken
			if (!mem_resp_valid && (rd_q.size() != 0) && (($random(seed) & 1) != 0)) begin
				mem_resp_valid = 1'b1;
				mem_resp_data  = rd_q[0];
			end
		end
	end

endmodule

/* tb_mmu_if.sv */
module tb_mmu_if;
	timeunit 1ns;
	timeprecision 1ps;

	// Requests per test
	localparam int N_BYPASS   = 16;
	localparam int N_XLATE    = 12;
	localparam int N_REUSE    = 10;
	localparam int N_FAULT    = 10;
	localparam int N_BP       = 40;
	localparam int TOTAL_REQS = N_BYPASS + N_XLATE + N_REUSE + N_FAULT + N_BP;
	// Page table sits in the last 4 KiB of memory
	localparam logic [31:0] PDT_BASE = 32'h0000_3000;

	logic                iCLOCK;
	logic                inRESET;
	logic                tlb_flush;
	mmu_pkg::mode_e      mode;
	logic [31:0]         pdt;
	logic                req_valid;
	logic                req_ready;
	logic                req_rw;
	logic [31:0]         req_addr;
	logic [31:0]         req_wdata;
	logic [3:0]          req_mask;
	logic                resp_valid;
	logic                resp_ready;
	logic [31:0]         resp_data;
	mmu_pkg::pte_flags_t resp_flags;
	logic                store_ack;
	logic                page_fault;
	logic                mem_req_valid;
	logic                mem_req_ready;
	logic                mem_req_rw;
	logic [31:0]         mem_req_addr;
	logic [31:0]         mem_req_wdata;
	logic [3:0]          mem_req_mask;
	logic                mem_resp_valid;
	logic                mem_resp_ready;
	logic [31:0]         mem_resp_data;
	int                  pt_reads;

	// Shadow of memory as the core should see it
	logic [31:0]         ref_mem [4096];
	logic [31:0]         exp_data [$];
	mmu_pkg::pte_flags_t exp_flags [$];
	int                  checks;
	int                  errors;
	int                  acks_exp;
	int                  acks_seen;
	int                  faults_exp;
	int                  faults_seen;
	int                  checks_at_start;
	int                  errors_at_start;
	int                  pt_at_start;
	string               test_name;
	bit                  bp_on;
	int                  seed = 32'h357e;
	int                  k;
	int                  vpn;
	logic [31:0]         va;
	int                  fault_vpn [N_FAULT] = '{1, 2, 4, 5, 9, 10, 11, 0, 12, 12};
	int                  xlate_vpn [N_XLATE] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 10, 11, 12};

	mmu_if i_mmu_if (.*);

	tb_mem_model i_mem (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.pt_base        (pdt),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_rw     (mem_req_rw),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_req_mask   (mem_req_mask),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_ready (mem_resp_ready),
		.mem_resp_data  (mem_resp_data),
		.pt_reads       (pt_reads)
	);

	always #4 iCLOCK = ~iCLOCK;

	// Background pattern, every address bit matters
	function automatic logic [31:0] fill_word(input int i);
		return 32'h6b00_0000 ^ (i * 32'h0001_0103);
	endfunction

	// Entry for page v; page 9 is left invalid
	function automatic logic [31:0] make_pte(input int v);
		logic [19:0] frame;
		logic [10:0] flags;
		frame = 20'(v % 3);
		flags = 11'(v * 37 + 5);
		return {frame, flags, (v != 9)};
	endfunction

	// Expected physical address and flags; returns 0 for an invalid entry
	function automatic logic ref_translate(input mmu_pkg::mode_e m, input logic [31:0] addr,
			output logic [31:0] pa, output mmu_pkg::pte_flags_t fl);
		logic [31:0] pte_addr;
		logic [31:0] pte;
		if (m == mmu_pkg::BYPASS) begin
			pa = addr;
			fl = '0;
			return 1'b1;
		end
		// Four bytes per page-table entry
		pte_addr = pdt + {addr[31:12], 2'b00};
		pte      = ref_mem[pte_addr[13:2]];
		pa       = {pte[31:12], addr[11:0]};
		fl       = pte[11:1];
		return pte[0];
	endfunction

	task automatic load_memory();
		int i;
		for (i = 0; i < 4096; i++) begin
			ref_mem[i]   = fill_word(i);
			i_mem.mem[i] = fill_word(i);
		end
		for (i = 0; i < 16; i++) begin
			ref_mem[PDT_BASE[13:2] + i]   = make_pte(i);
			i_mem.mem[PDT_BASE[13:2] + i] = make_pte(i);
		end
	endtask

	// Record what the access should do, then hand it to the DUT
	task automatic access(input logic rw, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] mask);
		logic [31:0]         pa;
		mmu_pkg::pte_flags_t fl;
		logic                ok;
		int                  lane;
		ok = ref_translate(mode, addr, pa, fl);
		if (!ok) begin
			faults_exp++;
		end else if (rw) begin
			acks_exp++;
			for (lane = 0; lane < 4; lane++)
				if (mask[lane])
					ref_mem[pa[13:2]][8*lane +: 8] = wdata[8*lane +: 8];
		end else begin
			exp_data.push_back(ref_mem[pa[13:2]]);
			exp_flags.push_back(fl);
		end
		@(negedge iCLOCK);
		req_valid = 1'b1;
		req_rw    = rw;
		req_addr  = addr;
		req_wdata = wdata;
		req_mask  = mask;
		@(posedge iCLOCK);
		while (!req_ready)
			@(posedge iCLOCK);
	endtask

	// Wait until every read, ack and fault has come back
	task automatic drain_all();
		@(negedge iCLOCK);
		req_valid = 1'b0;
		while (exp_data.size() != 0 || acks_seen < acks_exp || faults_seen < faults_exp)
			@(posedge iCLOCK);
		@(negedge iCLOCK);
	endtask

	task automatic flush_tlb();
		@(negedge iCLOCK);
		tlb_flush = 1'b1;
		@(negedge iCLOCK);
		tlb_flush = 1'b0;
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("Error %s: expected %0d %s, actual %0d", test_name, expected, what, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		checks_at_start = checks;
		errors_at_start = errors;
		pt_at_start     = pt_reads;
	endtask

	task automatic end_test();
		check_count("store acks", acks_exp, acks_seen);
		check_count("page faults", faults_exp, faults_seen);
		$display("Test %s done: %0d checks, %0d errors", test_name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	// Response checker, also counts the pulses
	always @(posedge iCLOCK) begin
		if (inRESET) begin
			if (store_ack)
				acks_seen++;
			if (page_fault)
				faults_seen++;
			if (resp_valid && resp_ready) begin
				if (exp_data.size() == 0) begin
					errors++;
					$display("Test %s got a response of %h with no read outstanding",
						test_name, resp_data);
				end else begin
					checks++;
					if (resp_data !== exp_data[0] || resp_flags !== exp_flags[0]) begin
						errors++;
						$display("Error %s: expected data %h flags %h, actual data %h flags %h",
							test_name, exp_data[0], exp_flags[0], resp_data, resp_flags);
					end
					void'(exp_data.pop_front());
					void'(exp_flags.pop_front());
				end
			end
		end
	end

	// Random core back-pressure when enabled
	always @(negedge iCLOCK) begin
		if (!inRESET)
			resp_ready = 1'b0;
		else if (bp_on)
			resp_ready = (($random(seed) & 1) != 0);
		else
			resp_ready = 1'b1;
	end

	// Watchdog
	initial begin
		repeat (TOTAL_REQS * 200) @(posedge iCLOCK);
		$display("Timeout after %0d cycles, the DUT stopped making progress", TOTAL_REQS * 200);
		$display("Checks failed");
		$finish;
	end

	initial begin
		iCLOCK      = 1'b0;
		inRESET     = 1'b0;
		tlb_flush   = 1'b0;
		mode        = mmu_pkg::BYPASS;
		pdt         = PDT_BASE;
		req_valid   = 1'b0;
		req_rw      = 1'b0;
		req_addr    = '0;
		req_wdata   = '0;
		req_mask    = '0;
		resp_ready  = 1'b0;
		bp_on       = 1'b0;
		checks      = 0;
		errors      = 0;
		acks_exp    = 0;
		acks_seen   = 0;
		faults_exp  = 0;
		faults_seen = 0;
		load_memory();
		repeat (2) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		// Bypass stores, then read them back
		begin_test("bypass");
		for (k = 0; k < N_BYPASS / 2; k++)
			access(1'b1, 32'h400 + k * 32'h44, 32'hc0de_0000 + k * 32'h1111,
				(k == 3) ? 4'b0110 : 4'hf);
		for (k = 0; k < N_BYPASS / 2; k++)
			access(1'b0, 32'h400 + k * 32'h44, '0, 4'hf);
		drain_all();
		end_test();

		// One-level translation, all through the walker
		mode = mmu_pkg::ONE_LEVEL;
		begin_test("translate");
		for (k = 0; k < N_XLATE; k++) begin
			vpn = xlate_vpn[k];
			va  = {vpn[19:0], 12'((vpn * 12'h124 + 8) & 12'hffc)};
			access(1'b0, va, '0, 4'hf);
		end
		drain_all();
		end_test();

		// Same page over and over, one walk per flush
		flush_tlb();
		begin_test("tlb_reuse");
		for (k = 0; k < N_REUSE - 2; k++)
			access(k == 2, {20'd6, 12'(k * 12'h40 + 4)}, 32'hfeed_0000 + k, 4'hf);
		drain_all();
		check_count("page-table reads", 1, pt_reads - pt_at_start);
		flush_tlb();
		access(1'b0, {20'd6, 12'h088}, '0, 4'hf);
		access(1'b0, {20'd6, 12'h004}, '0, 4'hf);
		drain_all();
		check_count("page-table reads", 2, pt_reads - pt_at_start);
		end_test();

		// Invalid entry in the middle of a stream
		begin_test("page_fault");
		for (k = 0; k < N_FAULT; k++) begin
			vpn = fault_vpn[k];
			va  = {vpn[19:0], 12'((k * 12'h88 + 12'h10) & 12'hffc)};
			access((k == 3) || (k == 8), va, 32'hbad0_0000 ^ k, 4'hf);
		end
		drain_all();
		end_test();

		// Random core and memory stalls, mixed traffic
		bp_on = 1'b1;
		begin_test("back_pressure");
		for (k = 0; k < N_BP; k++) begin
			vpn = (k * 7 + 3) % 16;
			if (vpn == 9)
				vpn = 14;
			va = {vpn[19:0], 12'((k * 52) & 12'hffc)};
			access((k % 4) == 1, va, 32'h5eed_0000 ^ (k * 32'h0101_0001),
				((k % 3) == 0) ? 4'b0011 : 4'hf);
		end
		drain_all();
		bp_on = 1'b0;
		end_test();

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
mmu_pkg.sv
mem_req_if.sv
resp_fifo.sv
mmu_tlb.sv
mmu_translate.sv
mmu_ctrl.sv
mmu_if.sv
tb_mem_model.sv
tb_mmu_if.sv
